// ==== logic/iterative_divider.sv ====
// iterative divider
// restoring 32-bit divide, signed or unsigned, quotient and remainder out
`timescale 1ns/100ps
`default_nettype none

module iterative_divider
  import muldiv_data_pkg::*;
#(
  parameter int ITER_BITS = 32
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    start,
  input  logic    is_signed,
  input  word_t   dividend,
  input  word_t   divisor,
  output result_u result,
  output logic    done
);

  localparam int CNT_W = $clog2(ITER_BITS + 1);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_CALC = 2'd1;
  localparam logic [1:0] S_FIX  = 2'd2;
  localparam logic [1:0] S_DONE = 2'd3;

  logic [1:0]       state;
  logic [CNT_W-1:0] cnt;
  logic             dvd_neg;
  logic             dvs_neg;
  logic             quo_neg;   // signs differ
  logic             rem_neg;   // follows the dividend
  word_t            dvs_mag;
  logic [64:0]      rq;        // remainder above, quotient below
  logic [64:0]      rq_shift;
  logic [32:0]      trial;

  assign dvd_neg = is_signed && dividend[31];
  assign dvs_neg = is_signed && divisor[31];

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_CALC;
            cnt   <= CNT_W'(ITER_BITS);
          end
        end
        S_CALC: begin
          cnt <= cnt - CNT_W'(1);
          if (cnt == CNT_W'(1)) state <= S_FIX;
        end
        S_FIX:   state <= S_DONE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // ------------------------------
  // one trial subtraction per step
  // ------------------------------
  assign rq_shift = {rq[63:0], 1'b0};
  assign trial    = rq_shift[64:32] - {1'b0, dvs_mag};

  always_ff @(posedge clk) begin
    if (start) begin
      rq      <= {33'b0, word_neg_if(dividend, dvd_neg)};
      dvs_mag <= word_neg_if(divisor, dvs_neg);
      quo_neg <= dvd_neg ^ dvs_neg;
      rem_neg <= dvd_neg;
    end else if (state == S_CALC) begin
      // negative trial means restore, quotient bit 0
      rq <= trial[32] ? rq_shift : {trial, rq_shift[31:1], 1'b1};
    end else if (state == S_FIX) begin
      result.div.pad_hi    <= '0;
      result.div.remainder <= word_neg_if(rq[63:32], rem_neg);
      result.div.pad_mid   <= '0;
      result.div.quotient  <= word_neg_if(rq[31:0], quo_neg);
    end
  end

  assign done = (state == S_DONE);

  // divisor is the low word of b*c, built one pass earlier
  a_divisor_nonzero: assert property (@(posedge clk) disable iff (reset)
    start |-> (divisor != '0));

endmodule

`default_nettype wire

// ==== logic/muldiv_cmd_pkg.sv ====
// muldiv command types
// function codes and the request bundle
`default_nettype none

package muldiv_cmd_pkg;

  import muldiv_data_pkg::*;

  typedef logic [2:0] muldiv_fn_t;

  localparam muldiv_fn_t FN_MUL  = 3'd0;
  localparam muldiv_fn_t FN_DIV  = 3'd1;
  localparam muldiv_fn_t FN_DIVU = 3'd2;
  localparam muldiv_fn_t FN_REM  = 3'd3;
  localparam muldiv_fn_t FN_REMU = 3'd4;  // highest legal code

  // 99 bits: fn, then the three operands
  typedef struct packed {
    muldiv_fn_t fn;
    word_t      a;
    word_t      b;
    word_t      c;
  } muldiv_req_t;

  // signed flavours of the divide pair
  function automatic logic fn_is_signed(input muldiv_fn_t fn);
    return (fn == FN_DIV) || (fn == FN_REM);
  endfunction

endpackage

`default_nettype wire

// ==== logic/muldiv_data_pkg.sv ====
// muldiv data types
// operand words, the 96-bit result word and its two views, sign helpers
`default_nettype none

package muldiv_data_pkg;

  localparam int WORD_W   = 32;
  localparam int RESULT_W = 3 * WORD_W;

  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [2*WORD_W-1:0] dword_t;

  // quotient low, remainder in the middle, zero pads around them
  typedef struct packed {
    logic [15:0] pad_hi;
    word_t       remainder;
    logic [15:0] pad_mid;
    word_t       quotient;
  } div_view_t;

  typedef union packed {
    logic [RESULT_W-1:0] product;  // mul view
    div_view_t           div;      // div/rem view
  } result_u;

  // which unit runs the second pass
  typedef logic stage_route_t;
  localparam stage_route_t ROUTE_MUL = 1'b0;
  localparam stage_route_t ROUTE_DIV = 1'b1;

  function automatic word_t word_neg_if(input word_t v, input logic neg);
    return neg ? (~v + word_t'(1)) : v;
  endfunction

  function automatic dword_t dword_neg_if(input dword_t v, input logic neg);
    return neg ? (~v + dword_t'(1)) : v;
  endfunction

endpackage

`default_nettype wire

// ==== logic/operand_stage.sv ====
// operand stage
// takes a request, keeps a and the code, runs the signed b*c shift-add pass
`timescale 1ns/100ps
`default_nettype none

module operand_stage
  import muldiv_cmd_pkg::*;
  import muldiv_data_pkg::*;
#(
  parameter int ITER_BITS = 32
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         start,
  input  muldiv_req_t  req,
  output dword_t       bc_product,
  output word_t        held_a,
  output stage_route_t route,
  output logic         div_signed,
  output logic         mul_start,
  output logic         div_start
);

  localparam int CNT_W = $clog2(ITER_BITS + 1);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_CALC = 2'd1;
  localparam logic [1:0] S_FIX  = 2'd2;
  localparam logic [1:0] S_DONE = 2'd3;

  logic [1:0]           state;
  logic [CNT_W-1:0]     cnt;
  muldiv_fn_t           fn_q;
  logic                 neg_q;     // sign of b*c
  dword_t               mcand;
  logic [ITER_BITS-1:0] mplier;
  dword_t               acc;
  logic                 bc_done;

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_CALC;
            cnt   <= CNT_W'(ITER_BITS);
          end
        end
        S_CALC: begin
          cnt <= cnt - CNT_W'(1);
          if (cnt == CNT_W'(1)) state <= S_FIX;  // last shift step
        end
        S_FIX:   state <= S_DONE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // ------------------------------
  // datapath
  // ------------------------------
  always_ff @(posedge clk) begin
    if (start) begin
      fn_q   <= req.fn;
      held_a <= req.a;
      neg_q  <= req.b[31] ^ req.c[31];
      mcand  <= {32'b0, word_neg_if(req.b, req.b[31])};
      mplier <= ITER_BITS'(word_neg_if(req.c, req.c[31]));
      acc    <= '0;
    end else if (state == S_CALC) begin
      if (mplier[0]) acc <= acc + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end else if (state == S_FIX) begin
      acc <= dword_neg_if(acc, neg_q);  // back to two's complement
    end
  end

  assign bc_done    = (state == S_DONE);
  assign bc_product = acc;
  assign route      = (fn_q == FN_MUL) ? ROUTE_MUL : ROUTE_DIV;
  assign div_signed = fn_is_signed(fn_q);

  // hand off to exactly one second-pass unit
  assign mul_start = bc_done && (route == ROUTE_MUL);
  assign div_start = bc_done && (route == ROUTE_DIV);

  // codes 5..7 have no meaning here
  a_fn_legal: assert property (@(posedge clk) disable iff (reset)
    start |-> (req.fn <= FN_REMU));

endmodule

`default_nettype wire

// ==== logic/response_stage.sv ====
// response stage
// tracks the request in flight, holds the finished result until taken
`timescale 1ns/100ps
`default_nettype none

module response_stage
  import muldiv_data_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    start,
  input  logic    mul_done,
  input  result_u mul_result,
  input  logic    div_done,
  input  result_u div_result,
  output logic    req_rdy,
  output result_u resp_result,
  output logic    resp_val,
  input  logic    resp_rdy
);

  logic busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      resp_val <= 1'b0;
    end else begin
      if (start) busy <= 1'b1;
      if (mul_done || div_done) resp_val <= 1'b1;
      if (resp_val && resp_rdy) begin  // handshake frees the unit
        resp_val <= 1'b0;
        busy     <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mul_done) resp_result <= mul_result;
    else if (div_done) resp_result <= div_result;
  end

  assign req_rdy = ~busy;

  a_one_done: assert property (@(posedge clk) disable iff (reset)
    !(mul_done && div_done));

  // stalled response stays put
  a_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)));

endmodule

`default_nettype wire

// ==== logic/three_input_muldiv.sv ====
// three-input muldiv unit
// b*c pass, then a*(b*c) or a/(b*c), one request in flight
`timescale 1ns/100ps
`default_nettype none

module three_input_muldiv
  import muldiv_cmd_pkg::*;
  import muldiv_data_pkg::*;
#(
  parameter int ITER_BITS = 32
) (
  input  logic        clk,
  input  logic        reset,
  input  muldiv_req_t req,
  input  logic        req_val,
  output logic        req_rdy,
  output result_u     resp_result,
  output logic        resp_val,
  input  logic        resp_rdy
);

  logic         req_start;
  dword_t       bc_product;
  word_t        held_a;
  logic         div_signed;
  logic         mul_start;
  logic         div_start;
  result_u      mul_result;
  logic         mul_done;
  result_u      div_result;
  logic         div_done;

  assign req_start = req_val && req_rdy;

  operand_stage #(.ITER_BITS(ITER_BITS)) u_operand (
    .clk        (clk),
    .reset      (reset),
    .start      (req_start),
    .req        (req),
    .bc_product (bc_product),
    .held_a     (held_a),
    .route      (),
    .div_signed (div_signed),
    .mul_start  (mul_start),
    .div_start  (div_start)
  );

  wide_multiplier #(.ITER_BITS(ITER_BITS)) u_mul (
    .clk          (clk),
    .reset        (reset),
    .start        (mul_start),
    .multiplicand (bc_product),
    .multiplier   (held_a),
    .result       (mul_result),
    .done         (mul_done)
  );

  iterative_divider #(.ITER_BITS(ITER_BITS)) u_div (
    .clk       (clk),
    .reset     (reset),
    .start     (div_start),
    .is_signed (div_signed),
    .dividend  (held_a),
    .divisor   (bc_product[31:0]),  // low word of b*c
    .result    (div_result),
    .done      (div_done)
  );

  response_stage u_response (
    .clk         (clk),
    .reset       (reset),
    .start       (req_start),
    .mul_done    (mul_done),
    .mul_result  (mul_result),
    .div_done    (div_done),
    .div_result  (div_result),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

endmodule

`default_nettype wire

// ==== logic/wide_multiplier.sv ====
// wide multiplier
// iterative signed 64x32 shift-add multiply, exact 96-bit product
`timescale 1ns/100ps
`default_nettype none

module wide_multiplier
  import muldiv_data_pkg::*;
#(
  parameter int ITER_BITS = 32
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    start,
  input  dword_t  multiplicand,
  input  word_t   multiplier,
  output result_u result,
  output logic    done
);

  localparam int CNT_W = $clog2(ITER_BITS + 1);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_CALC = 2'd1;
  localparam logic [1:0] S_FIX  = 2'd2;
  localparam logic [1:0] S_DONE = 2'd3;

  logic [1:0]           state;
  logic [CNT_W-1:0]     cnt;
  logic                 sign_q;
  logic [RESULT_W-1:0]  mcand;   // shifts left each step
  logic [ITER_BITS-1:0] mplier;  // shifts right each step
  logic [RESULT_W-1:0]  acc;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_CALC;
            cnt   <= CNT_W'(ITER_BITS);
          end
        end
        S_CALC: begin
          cnt <= cnt - CNT_W'(1);
          if (cnt == CNT_W'(1)) state <= S_FIX;
        end
        S_FIX:   state <= S_DONE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // ------------------------------
  // sign-magnitude shift-add
  // ------------------------------
  always_ff @(posedge clk) begin
    if (start) begin
      sign_q <= multiplicand[63] ^ multiplier[31];
      mcand  <= {32'b0, dword_neg_if(multiplicand, multiplicand[63])};
      mplier <= ITER_BITS'(word_neg_if(multiplier, multiplier[31]));
      acc    <= '0;
    end else if (state == S_CALC) begin
      if (mplier[0]) acc <= acc + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end else if (state == S_FIX) begin
      result.product <= sign_q ? (~acc + RESULT_W'(1)) : acc;
    end
  end

  assign done = (state == S_DONE);

  // one request at a time upstream
  a_no_restart: assert property (@(posedge clk) disable iff (reset)
    start |-> (state == S_IDLE));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it, and checks for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
    --top-module tb_three_input_muldiv -f tb.f -o sim_tb; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qxF '** PASS **'; then
  exit 0
else
  echo "pass line not found in simulation output"
  exit 1
fi

// ==== tb.f ====
logic/muldiv_data_pkg.sv
logic/muldiv_cmd_pkg.sv
logic/operand_stage.sv
logic/wide_multiplier.sv
logic/iterative_divider.sv
logic/response_stage.sv
logic/three_input_muldiv.sv
tb/tb_three_input_muldiv.sv

// ==== tb/golden_vectors.txt ====
// columns: fn a b c expected, all hex
// expected is the 96-bit word: product, or {pad, remainder, pad, quotient}
0 00000003 00000005 00000007 000000000000000000000069
0 FFFFFFFE 00000003 00000004 FFFFFFFFFFFFFFFFFFFFFFE8
0 FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFFFFFFFFFFFFFFFFFF
0 80000000 80000000 80000000 E00000000000000000000000
0 12345678 00000001 FFFFFFFF FFFFFFFFFFFFFFFFEDCBA988
0 00010001 00010001 00010001 000000000001000300030001
0 7FFFFFFF 00000002 FFFFFFFD FFFFFFFFFFFFFFFD00000006
0 80000000 FFFFFFFF 80000000 FFFFFFFFC000000000000000
0 80000001 80000000 00000001 000000003FFFFFFF80000000
0 FFFF0000 00010000 FFFF0000 000000000001000000000000
1 00000064 00000003 00000002 000000000004000000000010
3 00000064 00000003 00000002 000000000004000000000010
1 FFFFFF9C 00000003 00000002 0000FFFFFFFC0000FFFFFFF0
3 00000064 FFFFFFFD 00000002 0000000000040000FFFFFFF0
1 FFFFFF9C FFFFFFFD 00000002 0000FFFFFFFC000000000010
1 80000000 00000002 00000001 0000000000000000C0000000
3 FFFFFFF9 00000001 00000002 0000FFFFFFFF0000FFFFFFFD
1 7FFFFFFF 00010000 00010003 00000001FFFF000000002AAA
1 FFFFFFFE FFFFFFFF 00000001 000000000000000000000002
2 FFFFFFFF 00000010 00000001 00000000000F00000FFFFFFF
4 FFFFFFFF 00000010 00000001 00000000000F00000FFFFFFF
2 80000000 FFFFFFFF 00000001 000080000000000000000000
4 FFFFFFFE 80000000 00000001 00007FFFFFFE000000000001
2 90000000 FFFFFFFF FFFFFFF0 000000000000000009000000
2 FFFFFF9C 00000003 00000002 00000000000000002AAAAA9A

// ==== tb/tb_three_input_muldiv.sv ====
// testbench for the three-input muldiv unit
// replays golden vectors under random back-pressure and checks each response
`timescale 1ns/100ps
`default_nettype none

module tb_three_input_muldiv
  import muldiv_cmd_pkg::*;
  import muldiv_data_pkg::*;
();

  localparam int NUM_VEC     = 25;
  localparam int VEC_WORDS   = 5;   // fn, a, b, c, expected
  localparam int CHECK_W     = 96;
  localparam int MAX_LATENCY = 69;
  localparam int TIMEOUT     = NUM_VEC * 200 + 100;

  logic        clk = 1'b0;
  logic        reset;
  muldiv_req_t req;
  logic        req_val;
  logic        req_rdy;
  result_u     resp_result;
  logic        resp_val;
  logic        resp_rdy;

  logic [CHECK_W-1:0] golden [0:NUM_VEC*VEC_WORDS-1];

  int          n_checks   = 0;
  int          n_errors   = 0;
  int          cycle_cnt  = 0;
  logic [31:0] lcg_state  = 32'h83d9_4673;
  logic        stall_prev = 1'b0;
  result_u     held_result;

  three_input_muldiv #(.ITER_BITS(32)) dut (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  always #10 clk = ~clk;  // 20 ns period

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [CHECK_W-1:0] expected,
                             input logic [CHECK_W-1:0] actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("FAILED time %0t: %s expected %h, actual %h", $time, name, expected, actual);
    end
  endtask

  // ------------------------------
  // back-pressure and monitors
  // ------------------------------
  initial begin
    resp_rdy <= 1'b0;
    forever begin
      @(posedge clk);
      lcg_state = lcg_next(lcg_state);
      resp_rdy <= lcg_state[31];  // low about half the time
    end
  end

  // a stalled response must not move
  always @(negedge clk) begin
    if (!reset) begin
      if (stall_prev) begin
        check_value("resp_val", CHECK_W'(1), CHECK_W'(resp_val));
        check_value("resp_result", held_result, resp_result);
      end
      if (resp_val) check_value("req_rdy", CHECK_W'(0), CHECK_W'(req_rdy));
      stall_prev  = resp_val && !resp_rdy;
      held_result = resp_result;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT) begin
      $display("timeout: test did not finish within %0d cycles", TIMEOUT);
      $display("checks %0d, errors %0d", n_checks, n_errors);
      $display("** FAIL **");
      $finish;
    end
  end

  // ------------------------------
  // one request, one response
  // ------------------------------
  task automatic run_vector(input int idx);
    muldiv_req_t        v;
    logic [CHECK_W-1:0] expected;
    int                 lat;
    v.fn     = golden[idx*VEC_WORDS][2:0];
    v.a      = golden[idx*VEC_WORDS+1][31:0];
    v.b      = golden[idx*VEC_WORDS+2][31:0];
    v.c      = golden[idx*VEC_WORDS+3][31:0];
    expected = golden[idx*VEC_WORDS+4];
    lat      = 0;
    @(posedge clk);
    req     <= v;
    req_val <= 1'b1;
    @(posedge clk);  // taken here, unit is idle
    req_val <= 1'b0;
    do begin
      @(negedge clk);
      lat++;
      if (!resp_val) check_value("req_rdy", CHECK_W'(0), CHECK_W'(req_rdy));
    end while (!resp_val);
    check_value("latency within 69 cycles", CHECK_W'(1), CHECK_W'(lat <= MAX_LATENCY));
    check_value("resp_result", expected, resp_result);
    while (!resp_rdy) @(negedge clk);
    @(negedge clk);  // just past the handshake edge
    check_value("resp_val", CHECK_W'(0), CHECK_W'(resp_val));
    check_value("req_rdy", CHECK_W'(1), CHECK_W'(req_rdy));
  endtask

  initial begin
    reset   <= 1'b1;
    req     <= '0;
    req_val <= 1'b0;
    $readmemh("tb/golden_vectors.txt", golden);
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("req_rdy", CHECK_W'(1), CHECK_W'(req_rdy));
    check_value("resp_val", CHECK_W'(0), CHECK_W'(resp_val));
    for (int i = 0; i < NUM_VEC; i++) run_vector(i);
    repeat (3) @(posedge clk);
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
